// ==== lane_top.f ====
lane_pkg.sv
vrf_bank.sv
vrf_arbiter.sv
operand_requester.sv
operand_queue.sv
lane_top.sv
lane_top_properties.sv
tb_lane_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lane_top -f lane_top.f -o sim_lane_top
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_lane_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// ==== tb_lane_top.sv ====
`timescale 1ns/10ps

module tb_lane_top;
  import lane_pkg::*;

  localparam int unsigned BufferDepth = 2;
  localparam int unsigned CmdDepth    = 2;
  // Output words over all tests
  localparam int unsigned TotalWords     = 8 + 136 + 24 + 24 + 24;
  localparam int unsigned WatchdogCycles = TotalWords * 40;

  logic         clk;
  logic         rst_n;
  logic         cmd_req_a, cmd_req_b;
  operand_cmd_t cmd_a, cmd_b;
  logic         cmd_ack_a, cmd_ack_b;
  logic         vrf_wr_en;
  vrf_addr_t    vrf_wr_addr;
  elen_t        vrf_wr_data;
  elen_t        operand_a, operand_b;
  logic         operand_valid_a, operand_valid_b;
  logic         operand_ready_a, operand_ready_b;

  // Copy of the VRF contents for the reference model
  elen_t       vrf_img [64];
  elen_t       exp_a [$];
  elen_t       exp_b [$];
  elen_t       got_a [$];
  elen_t       got_b [$];
  logic [31:0] rng_q;
  logic        backpressure;
  int unsigned value_errors;
  int unsigned other_errors;

  lane_top #(
    .BufferDepth (BufferDepth),
    .CmdDepth    (CmdDepth)
  ) DUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .cmd_req_a_i       (cmd_req_a),
    .cmd_a_i           (cmd_a),
    .cmd_ack_a_o       (cmd_ack_a),
    .cmd_req_b_i       (cmd_req_b),
    .cmd_b_i           (cmd_b),
    .cmd_ack_b_o       (cmd_ack_b),
    .vrf_wr_en_i       (vrf_wr_en),
    .vrf_wr_addr_i     (vrf_wr_addr),
    .vrf_wr_data_i     (vrf_wr_data),
    .operand_a_o       (operand_a),
    .operand_valid_a_o (operand_valid_a),
    .operand_ready_a_i (operand_ready_a),
    .operand_b_o       (operand_b),
    .operand_valid_b_o (operand_valid_b),
    .operand_ready_b_i (operand_ready_b)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Output ready is random only while back-pressure is on
  always @(posedge clk) begin
    if (backpressure) begin
      rng_q = xorshift(rng_q);
      operand_ready_a <= rng_q[3];
      operand_ready_b <= rng_q[9] | rng_q[21];
    end else begin
      operand_ready_a <= 1'b1;
      operand_ready_b <= 1'b1;
    end
  end

  // A word moves at the next rising edge when valid and ready
  always @(negedge clk) begin
    if (rst_n && operand_valid_a && operand_ready_a) begin
      got_a.push_back(operand_a);
    end
    if (rst_n && operand_valid_b && operand_ready_b) begin
      got_b.push_back(operand_b);
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int unsigned widen_of(opqueue_conv_e conv);
    case (conv)
      ConvSExt2, ConvZExt2: return 2;
      ConvSExt4, ConvZExt4: return 4;
      ConvSExt8, ConvZExt8: return 8;
      default:              return 1;
    endcase
  endfunction

  // Output word k holds source elements extended and packed contiguously
  function automatic elen_t model_word(operand_cmd_t c, int unsigned k);
    int unsigned w, dw, n, bitpos;
    logic        sext;
    elen_t       elem, res;
    w    = 8 << int'(c.eew);
    dw   = w * widen_of(c.conv);
    n    = 64 / dw;
    sext = c.conv inside {ConvSExt2, ConvSExt4, ConvSExt8};
    res  = '0;
    for (int unsigned j = 0; j < n; j++) begin
      bitpos = (k * n + j) * w;
      elem   = vrf_img[int'(c.vs) * 8 + int'(bitpos / 64)] >> (bitpos % 64);
      if (w < 64) begin
        if (sext && elem[w-1]) begin
          elem = elem | ({64{1'b1}} << w);
        end else begin
          elem = elem & ~({64{1'b1}} << w);
        end
      end
      if (dw < 64) begin
        elem = elem & ~({64{1'b1}} << dw);
      end
      res = res | (elem << (j * dw));
    end
    return res;
  endfunction

  task automatic expect_cmd(input logic ch_b, input operand_cmd_t c);
    int unsigned nr;
    nr = (int'(c.vl) * (8 << int'(c.eew)) * widen_of(c.conv)) / 64;
    for (int unsigned k = 0; k < nr; k++) begin
      if (ch_b) begin
        exp_b.push_back(model_word(c, k));
      end else begin
        exp_a.push_back(model_word(c, k));
      end
    end
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_operand(input string name, input elen_t expected, input elen_t actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_ack(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %b actual %b", name, expected, actual);
      value_errors++;
    end
  endtask

  //////////////////////////////
  // Drivers
  //////////////////////////////

  task automatic load_vrf();
    elen_t word;
    for (int a = 0; a < 64; a++) begin
      rng_q = xorshift(rng_q);
      word[63:32] = rng_q;
      rng_q = xorshift(rng_q);
      word[31:0] = rng_q;
      vrf_img[a] = word;
      @(posedge clk);
      vrf_wr_en   <= 1'b1;
      vrf_wr_addr <= vrf_addr_t'(a);
      vrf_wr_data <= word;
    end
    @(posedge clk);
    vrf_wr_en <= 1'b0;
  endtask

  // Full four-phase handshake on one channel
  task automatic send_cmd(input logic ch_b, input operand_cmd_t c, input string name);
    @(posedge clk);
    if (ch_b) begin
      cmd_b     <= c;
      cmd_req_b <= 1'b1;
    end else begin
      cmd_a     <= c;
      cmd_req_a <= 1'b1;
    end
    @(negedge clk);
    // The requester has not seen req yet
    check_ack({name, " early ack"}, 1'b0, ch_b ? cmd_ack_b : cmd_ack_a);
    do @(negedge clk); while (!(ch_b ? cmd_ack_b : cmd_ack_a));
    @(posedge clk);
    if (ch_b) begin
      cmd_req_b <= 1'b0;
    end else begin
      cmd_req_a <= 1'b0;
    end
    do @(negedge clk); while (ch_b ? cmd_ack_b : cmd_ack_a);
  endtask

  // Wait for every expected word and compare both channels
  task automatic drain(input string name);
    while (got_a.size() < exp_a.size() || got_b.size() < exp_b.size()) begin
      @(posedge clk);
    end
    @(negedge clk);
    if (operand_valid_a || operand_valid_b) begin
      $display("%s: an output is still valid after its last expected word", name);
      other_errors++;
    end
    if (got_a.size() != exp_a.size() || got_b.size() != exp_b.size()) begin
      $display("%s: got %0d and %0d words on A and B, expected %0d and %0d", name,
               got_a.size(), got_b.size(), exp_a.size(), exp_b.size());
      other_errors++;
    end
    for (int i = 0; i < exp_a.size(); i++) begin
      check_operand($sformatf("%s A word %0d", name, i), exp_a[i], got_a[i]);
    end
    for (int i = 0; i < exp_b.size(); i++) begin
      check_operand($sformatf("%s B word %0d", name, i), exp_b[i], got_b[i]);
    end
    exp_a.delete();
    exp_b.delete();
    got_a.delete();
    got_b.delete();
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    check_ack("reset ack A", 1'b0, cmd_ack_a);
    check_ack("reset ack B", 1'b0, cmd_ack_b);
    check_ack("reset valid A", 1'b0, operand_valid_a);
    check_ack("reset valid B", 1'b0, operand_valid_b);
  endtask

  task automatic test_no_conv();
    operand_cmd_t c;
    c = '{vs: 3'd1, eew: EW64, conv: ConvNone, vl: 7'd8};
    expect_cmd(1'b0, c);
    send_cmd(1'b0, c, "no_conv");
    drain("no_conv");
  endtask

  task automatic test_widen();
    vew_e          eews  [6];
    opqueue_conv_e sconv [6];
    opqueue_conv_e zconv [6];
    vlen_t         vls   [6];
    operand_cmd_t  c;
    eews  = '{EW8, EW8, EW8, EW16, EW16, EW32};
    sconv = '{ConvSExt2, ConvSExt4, ConvSExt8, ConvSExt2, ConvSExt4, ConvSExt2};
    zconv = '{ConvZExt2, ConvZExt4, ConvZExt8, ConvZExt2, ConvZExt4, ConvZExt2};
    // Lengths that end part-way through a register
    vls   = '{7'd36, 7'd22, 7'd13, 7'd18, 7'd15, 7'd11};
    for (int i = 0; i < 6; i++) begin
      c = '{vs: vreg_t'(i), eew: eews[i], conv: sconv[i], vl: vls[i]};
      expect_cmd(1'b0, c);
      send_cmd(1'b0, c, "sext");
      drain($sformatf("sext case %0d", i));
      c.vs   = vreg_t'(7 - i);
      c.conv = zconv[i];
      expect_cmd(1'b1, c);
      send_cmd(1'b1, c, "zext");
      drain($sformatf("zext case %0d", i));
    end
  endtask

  task automatic test_dual(input logic stall, input string name);
    operand_cmd_t ca, cb;
    if (stall) begin
      ca = '{vs: 3'd3, eew: EW8, conv: ConvSExt4, vl: 7'd32};
      cb = '{vs: 3'd6, eew: EW32, conv: ConvNone, vl: 7'd16};
    end else begin
      ca = '{vs: 3'd2, eew: EW16, conv: ConvNone, vl: 7'd32};
      cb = '{vs: 3'd5, eew: EW8, conv: ConvZExt2, vl: 7'd64};
    end
    expect_cmd(1'b0, ca);
    expect_cmd(1'b1, cb);
    backpressure = stall;
    fork
      send_cmd(1'b0, ca, name);
      send_cmd(1'b1, cb, name);
    join
    drain(name);
    backpressure = 1'b0;
  endtask

  task automatic test_back_to_back();
    operand_cmd_t c1, c2;
    c1 = '{vs: 3'd4, eew: EW8, conv: ConvZExt8, vl: 7'd16};
    c2 = '{vs: 3'd7, eew: EW16, conv: ConvSExt2, vl: 7'd16};
    expect_cmd(1'b0, c1);
    expect_cmd(1'b0, c2);
    // Second command goes in while the first still drains
    send_cmd(1'b0, c1, "back_to_back first");
    send_cmd(1'b0, c2, "back_to_back second");
    drain("back_to_back");
  endtask

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    cmd_req_a       = 1'b0;
    cmd_req_b       = 1'b0;
    cmd_a           = '0;
    cmd_b           = '0;
    vrf_wr_en       = 1'b0;
    vrf_wr_addr     = '0;
    vrf_wr_data     = '0;
    operand_ready_a = 1'b1;
    operand_ready_b = 1'b1;
    rng_q           = 32'hdf7e;
    backpressure    = 1'b0;
    value_errors    = 0;
    other_errors    = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    test_reset_state();
    load_vrf();
    test_no_conv();
    test_widen();
    test_dual(1'b0, "dual");
    test_dual(1'b1, "backpressure");
    test_back_to_back();

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_lane_top

// ==== lane_top_properties.sv ====
`timescale 1ns/10ps

module lane_top_properties (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            cmd_req_a_i,
  input logic            cmd_ack_a_i,
  input logic            cmd_req_b_i,
  input logic            cmd_ack_b_i,
  input logic            gnt_a_i,
  input logic            gnt_b_i,
  input logic            valid_a_i,
  input logic            ready_a_i,
  input lane_pkg::elen_t operand_a_i,
  input logic            valid_b_i,
  input logic            ready_b_i,
  input lane_pkg::elen_t operand_b_i
);

  //////////////////////////////
  // Four-phase command handshake
  //////////////////////////////

  ack_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ack_a_i) |-> cmd_req_a_i) else $error("Channel A ack rose without req");
  ack_rise_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ack_b_i) |-> cmd_req_b_i) else $error("Channel B ack rose without req");

  // Ack may only drop once req is gone
  ack_fall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(cmd_ack_a_i) |-> !cmd_req_a_i) else $error("Channel A ack fell while req high");
  ack_fall_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(cmd_ack_b_i) |-> !cmd_req_b_i) else $error("Channel B ack fell while req high");

  //////////////////////////////
  // VRF port and outputs
  //////////////////////////////

  one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(gnt_a_i && gnt_b_i)) else $error("Both channels granted in one cycle");

  // Stalled output keeps its word
  hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_a_i && !ready_a_i |=> valid_a_i && $stable(operand_a_i))
    else $error("Channel A output changed while stalled");
  hold_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_b_i && !ready_b_i |=> valid_b_i && $stable(operand_b_i))
    else $error("Channel B output changed while stalled");

endmodule : lane_top_properties

bind lane_top lane_top_properties i_lane_top_properties (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmd_req_a_i (cmd_req_a_i),
  .cmd_ack_a_i (cmd_ack_a_o),
  .cmd_req_b_i (cmd_req_b_i),
  .cmd_ack_b_i (cmd_ack_b_o),
  .gnt_a_i     (gnt_a),
  .gnt_b_i     (gnt_b),
  .valid_a_i   (operand_valid_a_o),
  .ready_a_i   (operand_ready_a_i),
  .operand_a_i (operand_a_o),
  .valid_b_i   (operand_valid_b_o),
  .ready_b_i   (operand_ready_b_i),
  .operand_b_i (operand_b_o)
);

// ==== lane_top.sv ====
`timescale 1ns/10ps

module lane_top #(
  parameter int unsigned BufferDepth = 2,
  parameter int unsigned CmdDepth    = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Channel A command
  input  logic                   cmd_req_a_i,
  input  lane_pkg::operand_cmd_t cmd_a_i,
  output logic                   cmd_ack_a_o,
  // Channel B command
  input  logic                   cmd_req_b_i,
  input  lane_pkg::operand_cmd_t cmd_b_i,
  output logic                   cmd_ack_b_o,
  // VRF load port
  input  logic                   vrf_wr_en_i,
  input  lane_pkg::vrf_addr_t    vrf_wr_addr_i,
  input  lane_pkg::elen_t        vrf_wr_data_i,
  // Operands to the functional units
  output lane_pkg::elen_t        operand_a_o,
  output logic                   operand_valid_a_o,
  input  logic                   operand_ready_a_i,
  output lane_pkg::elen_t        operand_b_o,
  output logic                   operand_valid_b_o,
  input  logic                   operand_ready_b_i
);
  import lane_pkg::*;

  vrf_req_t   vrf_req_a, vrf_req_b;
  logic       gnt_a, gnt_b;
  logic       rd_en;
  vrf_addr_t  rd_addr;
  elen_t      rd_data;
  elen_t      data_a, data_b;
  logic       data_valid_a, data_valid_b;
  queue_cmd_t qcmd_a, qcmd_b;
  logic       qcmd_push_a, qcmd_push_b;
  logic       qcmd_full_a, qcmd_full_b;
  logic       queue_ready_a, queue_ready_b;

  //////////////////////////////
  // Register file and arbiter
  //////////////////////////////

  vrf_bank i_vrf_bank (
    .clk_i, .rst_ni,
    .rd_addr_i (rd_addr),       .rd_en_i   (rd_en),
    .rd_data_o (rd_data),
    .wr_en_i   (vrf_wr_en_i),   .wr_addr_i (vrf_wr_addr_i),
    .wr_data_i (vrf_wr_data_i)
  );

  vrf_arbiter i_vrf_arbiter (
    .clk_i, .rst_ni,
    .req_a_i        (vrf_req_a),    .req_b_i        (vrf_req_b),
    .gnt_a_o        (gnt_a),        .gnt_b_o        (gnt_b),
    .rd_en_o        (rd_en),        .rd_addr_o      (rd_addr),
    .rd_data_i      (rd_data),
    .data_a_o       (data_a),       .data_b_o       (data_b),
    .data_valid_a_o (data_valid_a), .data_valid_b_o (data_valid_b)
  );

  //////////////////////////////
  // Operand channels
  //////////////////////////////

  operand_requester i_requester_a (
    .clk_i, .rst_ni,
    .cmd_req_i     (cmd_req_a_i), .cmd_i       (cmd_a_i),     .cmd_ack_o (cmd_ack_a_o),
    .qcmd_o        (qcmd_a),      .qcmd_push_o (qcmd_push_a), .qcmd_full_i (qcmd_full_a),
    .vrf_req_o     (vrf_req_a),   .vrf_gnt_i   (gnt_a),
    .queue_ready_i (queue_ready_a)
  );

  operand_requester i_requester_b (
    .clk_i, .rst_ni,
    .cmd_req_i     (cmd_req_b_i), .cmd_i       (cmd_b_i),     .cmd_ack_o (cmd_ack_b_o),
    .qcmd_o        (qcmd_b),      .qcmd_push_o (qcmd_push_b), .qcmd_full_i (qcmd_full_b),
    .vrf_req_o     (vrf_req_b),   .vrf_gnt_i   (gnt_b),
    .queue_ready_i (queue_ready_b)
  );

  operand_queue #(
    .BufferDepth (BufferDepth),
    .CmdDepth    (CmdDepth)
  ) i_queue_a (
    .clk_i, .rst_ni,
    .qcmd_i           (qcmd_a),       .qcmd_push_i     (qcmd_push_a),
    .qcmd_full_o      (qcmd_full_a),
    .operand_i        (data_a),       .operand_valid_i (data_valid_a),
    .operand_issued_i (gnt_a),        .operand_queue_ready_o (queue_ready_a),
    .operand_o        (operand_a_o),  .operand_valid_o (operand_valid_a_o),
    .operand_ready_i  (operand_ready_a_i)
  );

  operand_queue #(
    .BufferDepth (BufferDepth),
    .CmdDepth    (CmdDepth)
  ) i_queue_b (
    .clk_i, .rst_ni,
    .qcmd_i           (qcmd_b),       .qcmd_push_i     (qcmd_push_b),
    .qcmd_full_o      (qcmd_full_b),
    .operand_i        (data_b),       .operand_valid_i (data_valid_b),
    .operand_issued_i (gnt_b),        .operand_queue_ready_o (queue_ready_b),
    .operand_o        (operand_b_o),  .operand_valid_o (operand_valid_b_o),
    .operand_ready_i  (operand_ready_b_i)
  );

endmodule : lane_top

// ==== operand_queue.sv ====
`timescale 1ns/10ps

module operand_queue #(
  parameter int unsigned BufferDepth = 2,
  parameter int unsigned CmdDepth    = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lane_pkg::queue_cmd_t qcmd_i,
  input  logic                 qcmd_push_i,
  output logic                 qcmd_full_o,
  input  lane_pkg::elen_t      operand_i,
  input  logic                 operand_valid_i,
  input  logic                 operand_issued_i,
  output logic                 operand_queue_ready_o,
  output lane_pkg::elen_t      operand_o,
  output logic                 operand_valid_o,
  input  logic                 operand_ready_i
);
  import lane_pkg::*;

  localparam int unsigned CmdPtrW = (CmdDepth > 1) ? $clog2(CmdDepth) : 1;
  localparam int unsigned BufPtrW = (BufferDepth > 1) ? $clog2(BufferDepth) : 1;
  localparam int unsigned CmdCntW = $clog2(CmdDepth + 1);
  localparam int unsigned BufCntW = $clog2(BufferDepth + 1);

  //////////////////////////////
  // Command buffer
  //////////////////////////////

  queue_cmd_t         cmd_mem [CmdDepth];
  queue_cmd_t         cmd;
  logic [CmdPtrW-1:0] cmd_wr_ptr_q, cmd_rd_ptr_q;
  logic [CmdCntW-1:0] cmd_cnt_q;
  logic               cmd_pop;

  assign cmd         = cmd_mem[cmd_rd_ptr_q];
  assign qcmd_full_o = (cmd_cnt_q == CmdCntW'(CmdDepth));

  always_ff @(posedge clk_i) begin
    if (qcmd_push_i) begin
      cmd_mem[cmd_wr_ptr_q] <= qcmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_wr_ptr_q <= '0;
      cmd_rd_ptr_q <= '0;
      cmd_cnt_q    <= '0;
    end else begin
      if (qcmd_push_i) begin
        cmd_wr_ptr_q <= (cmd_wr_ptr_q == CmdPtrW'(CmdDepth - 1)) ? '0 : cmd_wr_ptr_q + 1'b1;
      end
      if (cmd_pop) begin
        cmd_rd_ptr_q <= (cmd_rd_ptr_q == CmdPtrW'(CmdDepth - 1)) ? '0 : cmd_rd_ptr_q + 1'b1;
      end
      cmd_cnt_q <= cmd_cnt_q + CmdCntW'(qcmd_push_i) - CmdCntW'(cmd_pop);
    end
  end

  //////////////////////////////
  // Input buffer and credits
  //////////////////////////////

  elen_t              ibuf_mem [BufferDepth];
  elen_t              ibuf_head;
  logic [BufPtrW-1:0] ibuf_wr_ptr_q, ibuf_rd_ptr_q;
  logic [BufCntW-1:0] ibuf_cnt_q;
  // Words in the buffer plus reads still in flight
  logic [BufCntW-1:0] credit_q;
  logic               ibuf_pop;

  assign ibuf_head             = ibuf_mem[ibuf_rd_ptr_q];
  assign operand_queue_ready_o = (credit_q < BufCntW'(BufferDepth));

  always_ff @(posedge clk_i) begin
    if (operand_valid_i) begin
      ibuf_mem[ibuf_wr_ptr_q] <= operand_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ibuf_wr_ptr_q <= '0;
      ibuf_rd_ptr_q <= '0;
      ibuf_cnt_q    <= '0;
      credit_q      <= '0;
    end else begin
      if (operand_valid_i) begin
        ibuf_wr_ptr_q <= (ibuf_wr_ptr_q == BufPtrW'(BufferDepth - 1)) ? '0 : ibuf_wr_ptr_q + 1'b1;
      end
      if (ibuf_pop) begin
        ibuf_rd_ptr_q <= (ibuf_rd_ptr_q == BufPtrW'(BufferDepth - 1)) ? '0 : ibuf_rd_ptr_q + 1'b1;
      end
      ibuf_cnt_q <= ibuf_cnt_q + BufCntW'(operand_valid_i) - BufCntW'(ibuf_pop);
      credit_q   <= credit_q + BufCntW'(operand_issued_i) - BufCntW'(ibuf_pop);
    end
  end

  //////////////////////////////
  // Widening conversion
  //////////////////////////////

  logic [2:0] select_d, select_q;
  logic [1:0] fsh;
  logic       is_sext;
  elen_t      slice;
  elen_t      conv_operand;

  // log2 of the widening factor
  always_comb begin
    unique case (ext_factor(cmd.conv))
      2:       fsh = 2'd1;
      4:       fsh = 2'd2;
      8:       fsh = 2'd3;
      default: fsh = 2'd0;
    endcase
  end

  assign is_sext = cmd.conv inside {ConvSExt2, ConvSExt4, ConvSExt8};
  // Part of the head word that feeds this output word
  assign slice   = ibuf_head >> ({select_q, 6'b0} >> fsh);

  always_comb begin : p_conv
    conv_operand = ibuf_head;
    unique case ({fsh, cmd.eew})
      {2'd1, EW8}: for (int e = 0; e < 4; e++)
        conv_operand[16*e +: 16] = {{8{is_sext & slice[8*e+7]}}, slice[8*e +: 8]};
      {2'd1, EW16}: for (int e = 0; e < 2; e++)
        conv_operand[32*e +: 32] = {{16{is_sext & slice[16*e+15]}}, slice[16*e +: 16]};
      {2'd1, EW32}: conv_operand = {{32{is_sext & slice[31]}}, slice[31:0]};
      {2'd2, EW8}: for (int e = 0; e < 2; e++)
        conv_operand[32*e +: 32] = {{24{is_sext & slice[8*e+7]}}, slice[8*e +: 8]};
      {2'd2, EW16}: conv_operand = {{48{is_sext & slice[15]}}, slice[15:0]};
      {2'd3, EW8}:  conv_operand = {{56{is_sext & slice[7]}}, slice[7:0]};
      default: ;
    endcase
  end

  //////////////////////////////
  // Output sequencing
  //////////////////////////////

  vlen_t vl_d, vl_q;

  assign operand_o       = conv_operand;
  assign operand_valid_o = (ibuf_cnt_q != '0) && (cmd_cnt_q != '0);

  always_comb begin : p_output
    ibuf_pop = 1'b0;
    cmd_pop  = 1'b0;
    select_d = select_q;
    vl_d     = vl_q;
    if (operand_valid_o && operand_ready_i) begin
      vl_d     = vl_q + vlen_t'(elems_per_word(cmd.eew) >> fsh);
      select_d = select_q + 1'b1;
      // Last slice of the head word
      if (select_q == 3'(ext_factor(cmd.conv) - 1)) begin
        ibuf_pop = 1'b1;
        select_d = '0;
      end
      // Vector length reached
      if (vl_d >= cmd.vl) begin
        ibuf_pop = 1'b1;
        cmd_pop  = 1'b1;
        select_d = '0;
        vl_d     = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      select_q <= '0;
      vl_q     <= '0;
    end else begin
      select_q <= select_d;
      vl_q     <= vl_d;
    end
  end

endmodule : operand_queue

// ==== operand_requester.sv ====
`timescale 1ns/10ps

module operand_requester (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cmd_req_i,
  input  lane_pkg::operand_cmd_t cmd_i,
  output logic                   cmd_ack_o,
  output lane_pkg::queue_cmd_t   qcmd_o,
  output logic                   qcmd_push_o,
  input  logic                   qcmd_full_i,
  output lane_pkg::vrf_req_t     vrf_req_o,
  input  logic                   vrf_gnt_i,
  input  logic                   queue_ready_i
);
  import lane_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    Ack,
    Issue,
    WaitReqLow
  } state_e;

  state_e     state_d, state_q;
  vrf_addr_t  addr_d, addr_q;
  vlen_t      word_cnt_d, word_cnt_q;
  vlen_t      nr_reads_d, nr_reads_q;
  logic [7:0] rounded_vl;

  // vl rounded up to a whole number of source words
  assign rounded_vl = 8'(cmd_i.vl) + 8'(elems_per_word(cmd_i.eew)) - 8'd1;

  assign qcmd_o.eew  = cmd_i.eew;
  assign qcmd_o.conv = cmd_i.conv;
  assign qcmd_o.vl   = cmd_i.vl;

  assign cmd_ack_o = (state_q != Idle);

  always_comb begin
    state_d         = state_q;
    addr_d          = addr_q;
    word_cnt_d      = word_cnt_q;
    nr_reads_d      = nr_reads_q;
    qcmd_push_o     = 1'b0;
    vrf_req_o.valid = 1'b0;
    vrf_req_o.addr  = addr_q;

    unique case (state_q)
      Idle: begin
        // Take the command only if the queue can hold it
        if (cmd_req_i && !qcmd_full_i) begin
          qcmd_push_o = 1'b1;
          addr_d      = vrf_addr_t'(cmd_i.vs * NrWordsPerReg);
          word_cnt_d  = '0;
          nr_reads_d  = vlen_t'(rounded_vl >> (3 - int'(cmd_i.eew)));
          state_d     = Ack;
        end
      end
      Ack: begin
        state_d = Issue;
      end
      Issue: begin
        // Only ask while the queue has credits
        vrf_req_o.valid = queue_ready_i;
        if (vrf_gnt_i) begin
          addr_d     = addr_q + 1'b1;
          word_cnt_d = word_cnt_q + 1'b1;
          if (word_cnt_d == nr_reads_q) begin
            state_d = WaitReqLow;
          end
        end
      end
      WaitReqLow: begin
        if (!cmd_req_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      addr_q     <= '0;
      word_cnt_q <= '0;
      nr_reads_q <= '0;
    end else begin
      state_q    <= state_d;
      addr_q     <= addr_d;
      word_cnt_q <= word_cnt_d;
      nr_reads_q <= nr_reads_d;
    end
  end

endmodule : operand_requester

// ==== vrf_arbiter.sv ====
`timescale 1ns/10ps

module vrf_arbiter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lane_pkg::vrf_req_t  req_a_i,
  input  lane_pkg::vrf_req_t  req_b_i,
  output logic                gnt_a_o,
  output logic                gnt_b_o,
  output logic                rd_en_o,
  output lane_pkg::vrf_addr_t rd_addr_o,
  input  lane_pkg::elen_t     rd_data_i,
  output lane_pkg::elen_t     data_a_o,
  output lane_pkg::elen_t     data_b_o,
  output logic                data_valid_a_o,
  output logic                data_valid_b_o
);
  import lane_pkg::*;

  // High when B won the last arbitration
  logic last_b_q;
  // Owner of the read that is in flight
  logic owner_b_q;
  logic rvalid_q;

  // Round-robin: the last winner yields on a conflict
  always_comb begin
    gnt_a_o = req_a_i.valid && (!req_b_i.valid || last_b_q);
    gnt_b_o = req_b_i.valid && (!req_a_i.valid || !last_b_q);
    rd_en_o = gnt_a_o || gnt_b_o;
    rd_addr_o = gnt_b_o ? req_b_i.addr : req_a_i.addr;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_b_q  <= 1'b1;
      owner_b_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      if (rd_en_o) begin
        last_b_q <= gnt_b_o;
      end
      owner_b_q <= gnt_b_o;
      rvalid_q  <= rd_en_o;
    end
  end

  // Read data comes back one cycle after the grant
  assign data_a_o       = rd_data_i;
  assign data_b_o       = rd_data_i;
  assign data_valid_a_o = rvalid_q && !owner_b_q;
  assign data_valid_b_o = rvalid_q && owner_b_q;

endmodule : vrf_arbiter

// ==== vrf_bank.sv ====
`timescale 1ns/10ps

module vrf_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lane_pkg::vrf_addr_t rd_addr_i,
  input  logic                rd_en_i,
  output lane_pkg::elen_t     rd_data_o,
  input  logic                wr_en_i,
  input  lane_pkg::vrf_addr_t wr_addr_i,
  input  lane_pkg::elen_t     wr_data_i
);
  import lane_pkg::*;

  localparam int unsigned NrWords = 2 ** $bits(vrf_addr_t);

  elen_t mem [NrWords];
  elen_t rd_data_q;

  // Write port
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read, sees the contents before a same-cycle write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_q <= '0;
    end else if (rd_en_i) begin
      rd_data_q <= mem[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule : vrf_bank

// ==== lane_pkg.sv ====
package lane_pkg;

  // One VRF word
  typedef logic [63:0] elen_t;

  // Register number, 8 vector registers
  typedef logic [2:0] vreg_t;

  localparam int unsigned NrWordsPerReg = 8;

  // Word address: register number and word index
  typedef logic [5:0] vrf_addr_t;

  // Element count, 1 to 64
  typedef logic [6:0] vlen_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef enum logic [2:0] {
    ConvNone,
    ConvSExt2,
    ConvSExt4,
    ConvSExt8,
    ConvZExt2,
    ConvZExt4,
    ConvZExt8
  } opqueue_conv_e;

  typedef struct packed {
    vreg_t         vs;
    vew_e          eew;
    opqueue_conv_e conv;
    vlen_t         vl;
  } operand_cmd_t;

  // Part of the command the queue needs
  typedef struct packed {
    vew_e          eew;
    opqueue_conv_e conv;
    vlen_t         vl;
  } queue_cmd_t;

  typedef struct packed {
    logic      valid;
    vrf_addr_t addr;
  } vrf_req_t;

  // Source elements held in one 64-bit word
  function automatic int unsigned elems_per_word(vew_e eew);
    return 8 >> int'(eew);
  endfunction

  // Widening factor of a conversion
  function automatic int unsigned ext_factor(opqueue_conv_e conv);
    unique case (conv)
      ConvSExt2, ConvZExt2: return 2;
      ConvSExt4, ConvZExt4: return 4;
      ConvSExt8, ConvZExt8: return 8;
      default:              return 1;
    endcase
  endfunction

endpackage : lane_pkg
